/* src.f */
rtl/lsq_pkg.sv
rtl/dmem_if.sv
rtl/load_store_queue.sv
rtl/data_ram.sv
rtl/lsq_top.sv
tb/tb_clock_gen.sv
tb/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - rtl/lsq_pkg.sv
  - rtl/dmem_if.sv
  - rtl/load_store_queue.sv
  - rtl/data_ram.sv
  - rtl/lsq_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/lsq_tb.sv

/* tb/lsq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_tb;
    import lsq_pkg::*;

    typedef enum logic [2:0] {
        OP_FILL, OP_STORE, OP_GRANT, OP_LOAD, OP_CDB, OP_FLUSH, OP_FULL, OP_BURST
    } op_t;

    // an exp of zero leaves the expected value to the model
    typedef struct packed {
        op_t       op;
        rob_tag_t  tag;
        rob_tag_t  qj;
        mem_size_t size;
        logic      rnd;
        word_t     base;
        word_t     imm;
        word_t     data;
        word_t     exp;
    } row_t;

    localparam int NUM_ROWS  = 20;
    localparam int TIMEOUT   = 100;
    localparam int SEL_LOAD  = 0;
    localparam int SEL_STORE = 1;
    localparam int SEL_FULL  = 2;
    localparam int SEL_RST   = 3;

    logic                      clk;
    logic                      rst_n;
    logic                      entry_valid;
    lsq_entry_t                entry;
    rob_tag_t                  head_tag;
    logic                      head_is_store;
    logic                      flush;
    logic [NUM_CDB-1:0]        cdb_valid;
    rob_tag_t [NUM_CDB-1:0]    cdb_tag;
    word_t [NUM_CDB-1:0]       cdb_value;
    logic                      lsq_full;
    logic                      load_valid;
    rob_tag_t                  load_tag;
    word_t                     load_value;
    logic                      store_done;

    row_t       rows [NUM_ROWS];
    logic [7:0] model_mem [4*RAM_WORDS];
    word_t      rng;
    word_t      last_base;
    // store parked until its grant, load parked until its broadcast
    rob_tag_t   st_tag;
    mem_size_t  st_size;
    word_t      st_addr;
    word_t      st_data;
    rob_tag_t   ld_tag;
    word_t      ld_imm;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    lsq_top DUT (
        .clk(clk), .rst_n(rst_n), .entry_valid(entry_valid), .entry(entry),
        .head_tag(head_tag), .head_is_store(head_is_store), .flush(flush),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .lsq_full(lsq_full), .load_valid(load_valid), .load_tag(load_tag),
        .load_value(load_value), .store_done(store_done)
    );

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int size_bytes(input mem_size_t size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // little endian so the low data bytes land in the addressed lanes
    task automatic write_model(input mem_size_t size, input word_t addr, input word_t data);
        int n;
        int a;
        n = size_bytes(size);
        a = int'(addr[9:0]) & ~(n - 1);
        for (int b = 0; b < n; b++) begin
            model_mem[a + b] = data[8*b +: 8];
        end
    endtask

    function automatic word_t read_model(input word_t addr);
        int a;
        a = int'(addr[9:0]) & ~3;
        return {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
    endfunction

    function automatic lsq_entry_t make_entry(input logic st, input mem_size_t size,
        input rob_tag_t tag, input rob_tag_t qj, input word_t vj, input rob_tag_t qk,
        input word_t vk, input word_t imm);
        return '{1'b1, st, size, tag, qj, vj, qk, vk, imm};
    endfunction

    function automatic logic level_of(input int sel);
        case (sel)
            SEL_LOAD:  return load_valid;
            SEL_STORE: return store_done;
            SEL_FULL:  return lsq_full;
            default:   return rst_n;
        endcase
    endfunction

    task automatic stop_run(input string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    task automatic wait_level(input int sel, input logic val, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (level_of(sel) !== val) begin
            n++;
            if (n > TIMEOUT) begin
                stop_run({"timed out waiting for ", what});
            end
            @(negedge clk);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("load_valid", load_valid, 0);
            check_value("store_done", store_done, 0);
        end
    endtask

    task automatic push_entry(input lsq_entry_t e);
        @(posedge clk);
        entry_valid <= 1'b1;
        entry       <= e;
    endtask

    task automatic release_entry();
        @(posedge clk);
        entry_valid <= 1'b0;
    endtask

    task automatic enqueue(input lsq_entry_t e);
        wait_level(SEL_FULL, 1'b0, "lsq_full to drop");
        push_entry(e);
        release_entry();
    endtask

    task automatic grant_store(input rob_tag_t tag, input mem_size_t size,
        input word_t addr, input word_t data);
        @(posedge clk);
        head_tag      <= tag;
        head_is_store <= 1'b1;
        wait_level(SEL_STORE, 1'b1, "store_done");
        write_model(size, addr, data);
        @(posedge clk);
        head_is_store <= 1'b0;
    endtask

    task automatic check_load(input rob_tag_t tag, input word_t addr, input word_t exp);
        wait_level(SEL_LOAD, 1'b1, "load_valid");
        check_value("load_tag", load_tag, tag);
        check_value("load_value", load_value, read_model(addr));
        if (exp != 0) begin
            check_value("load_value", load_value, exp);
        end
    endtask

    task automatic apply_row(input row_t r);
        word_t base;
        word_t data;
        base = r.base;
        data = r.data;
        case (r.op)
            OP_FILL: begin
                for (int w = 0; w < RAM_WORDS; w++) begin
                    rng = xorshift(rng);
                    data = rng ^ word_t'(4 * w);
                    enqueue(make_entry(1'b1, SIZE_WORD, r.tag, 0, 4 * w, 0, data, 0));
                    grant_store(r.tag, SIZE_WORD, 4 * w, data);
                end
            end
            OP_STORE: begin
                if (r.rnd) begin
                    rng = xorshift(rng);
                    base = {22'd0, rng[9:0]} & ~word_t'(size_bytes(r.size) - 1);
                    rng = xorshift(rng);
                    data = rng;
                    last_base = base;
                end
                enqueue(make_entry(1'b1, r.size, r.tag, 0, base, 0, data, r.imm));
                // ready operands but the grant names another tag and then none
                @(posedge clk);
                head_tag      <= rob_tag_t'(r.tag + 1);
                head_is_store <= 1'b1;
                expect_quiet(4);
                @(posedge clk);
                head_tag      <= r.tag;
                head_is_store <= 1'b0;
                expect_quiet(4);
                st_tag  = r.tag;
                st_size = r.size;
                st_addr = base + r.imm;
                st_data = data;
            end
            OP_GRANT: grant_store(st_tag, st_size, st_addr, st_data);
            OP_LOAD: begin
                if (r.rnd) begin
                    base = last_base;
                end
                enqueue(make_entry(1'b0, SIZE_WORD, r.tag, r.qj, (r.qj != 0) ? 0 : base,
                    0, 0, r.imm));
                if (r.qj == 0) begin
                    check_load(r.tag, base + r.imm, r.exp);
                end else begin
                    ld_tag = r.tag;
                    ld_imm = r.imm;
                    expect_quiet(10);
                end
            end
            OP_CDB: begin
                // lane 0 carries a tag nobody waits on
                @(posedge clk);
                cdb_valid    <= '1;
                cdb_tag[0]   <= rob_tag_t'(r.qj + 1);
                cdb_value[0] <= ~base;
                cdb_tag[1]   <= r.qj;
                cdb_value[1] <= base;
                @(posedge clk);
                cdb_valid    <= '0;
                check_load(ld_tag, base + ld_imm, r.exp);
            end
            OP_FLUSH: begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                expect_quiet(8);
                check_value("lsq_full", lsq_full, 0);
            end
            OP_FULL: begin
                check_value("lsq_full", lsq_full, 0);
                // loads blocked on qj, stores blocked on qk
                for (int k = 0; k < LSQ_DEPTH; k++) begin
                    push_entry(make_entry(k[0], SIZE_WORD, r.tag, k[0] ? 0 : r.qj,
                        base + 4 * k, k[0] ? r.qj : 0, data, 0));
                end
                release_entry();
                wait_level(SEL_FULL, 1'b1, "lsq_full");
            end
            default: begin
                // the first results come back while later loads are still entered
                fork
                    begin
                        for (int k = 0; k < int'(r.data); k++) begin
                            push_entry(make_entry(1'b0, SIZE_WORD, rob_tag_t'(r.tag + k), 0,
                                base + 4 * k, 0, 0, r.imm));
                        end
                        release_entry();
                    end
                    begin
                        for (int k = 0; k < int'(r.data); k++) begin
                            check_load(rob_tag_t'(r.tag + k), base + r.imm + 4 * k, 0);
                        end
                    end
                join
            end
        endcase
    endtask

    initial begin
        entry_valid   = 1'b0;
        entry         = '0;
        head_tag      = '0;
        head_is_store = 1'b0;
        flush         = 1'b0;
        cdb_valid     = '0;
        cdb_tag       = '0;
        cdb_value     = '0;
        rng           = 32'h27309dd5;
        last_base     = '0;
        //           op        tag   qj    size       rnd   base      imm    data          exp
        rows[0]  = '{OP_FILL,  3'd1, 3'd0, SIZE_WORD, 1'b0, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[1]  = '{OP_STORE, 3'd1, 3'd0, SIZE_WORD, 1'b0, 32'h40,  32'h0, 32'hdeadbeef, 32'h0};
        rows[2]  = '{OP_GRANT, 3'd1, 3'd0, SIZE_WORD, 1'b0, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[3]  = '{OP_LOAD,  3'd2, 3'd0, SIZE_WORD, 1'b0, 32'h40,  32'h0, 32'h0, 32'hdeadbeef};
        rows[4]  = '{OP_STORE, 3'd3, 3'd0, SIZE_BYTE, 1'b0, 32'h80,  32'h1, 32'ha5,        32'h0};
        rows[5]  = '{OP_GRANT, 3'd3, 3'd0, SIZE_BYTE, 1'b0, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[6]  = '{OP_LOAD,  3'd4, 3'd0, SIZE_WORD, 1'b0, 32'h80,  32'h0, 32'h0,        32'h0};
        rows[7]  = '{OP_STORE, 3'd5, 3'd0, SIZE_HALF, 1'b1, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[8]  = '{OP_GRANT, 3'd5, 3'd0, SIZE_HALF, 1'b0, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[9]  = '{OP_LOAD,  3'd6, 3'd0, SIZE_WORD, 1'b1, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[10] = '{OP_STORE, 3'd1, 3'd0, SIZE_BYTE, 1'b1, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[11] = '{OP_GRANT, 3'd1, 3'd0, SIZE_BYTE, 1'b0, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[12] = '{OP_LOAD,  3'd2, 3'd0, SIZE_WORD, 1'b1, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[13] = '{OP_LOAD,  3'd3, 3'd5, SIZE_WORD, 1'b0, 32'h0,   32'h8, 32'h0,        32'h0};
        rows[14] = '{OP_CDB,   3'd0, 3'd5, SIZE_WORD, 1'b0, 32'h100, 32'h0, 32'h0,        32'h0};
        rows[15] = '{OP_FULL,  3'd4, 3'd7, SIZE_WORD, 1'b0, 32'h300, 32'h0, 32'hffffffff, 32'h0};
        rows[16] = '{OP_FLUSH, 3'd0, 3'd0, SIZE_WORD, 1'b0, 32'h0,   32'h0, 32'h0,        32'h0};
        rows[17] = '{OP_LOAD,  3'd1, 3'd0, SIZE_WORD, 1'b0, 32'h304, 32'h0, 32'h0,        32'h0};
        rows[18] = '{OP_LOAD,  3'd2, 3'd0, SIZE_WORD, 1'b0, 32'h308, 32'h4, 32'h0,        32'h0};
        rows[19] = '{OP_BURST, 3'd1, 3'd0, SIZE_WORD, 1'b0, 32'h40,  32'h0, 32'd5,        32'h0};
        wait_level(SEL_RST, 1'b1, "reset release");
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end
        $display("No errors");
        $finish;
    end
endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule

`default_nettype wire

/* rtl/lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
    input  logic                                     clk,
    input  logic                                     rst_n,

    // from the ROB
    input  logic                                     entry_valid,
    input  lsq_pkg::lsq_entry_t                      entry,
    input  lsq_pkg::rob_tag_t                        head_tag,
    input  logic                                     head_is_store,
    input  logic                                     flush,

    // common data bus lanes
    input  logic [lsq_pkg::NUM_CDB-1:0]              cdb_valid,
    input  lsq_pkg::rob_tag_t [lsq_pkg::NUM_CDB-1:0] cdb_tag,
    input  lsq_pkg::word_t [lsq_pkg::NUM_CDB-1:0]    cdb_value,

    // back to the ROB
    output logic                                     lsq_full,
    output logic                                     load_valid,
    output lsq_pkg::rob_tag_t                        load_tag,
    output lsq_pkg::word_t                           load_value,
    output logic                                     store_done
);

    // queue to data memory
    dmem_if mem_bus ();

    load_store_queue u_lsq (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .entry_valid   (entry_valid),
        .entry         (entry),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .head_tag      (head_tag),
        .head_is_store (head_is_store),
        .lsq_full      (lsq_full),
        .load_valid    (load_valid),
        .load_tag      (load_tag),
        .load_value    (load_value),
        .store_done    (store_done),
        .mem           (mem_bus.lsq)
    );

    // stands in for the data cache
    data_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .mem   (mem_bus.ram)
    );

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    dmem_if.ram  mem
);
    import lsq_pkg::*;

    word_t     ram_q [RAM_WORDS];
    ram_addr_t index;
    logic      sample;
    logic      resp_q;
    word_t     rdata_q;

    // bits 1:0 only pick a lane within the word
    assign index = mem.addr[$bits(ram_addr_t)+1:2];

    // a held request is taken once, then waits for its resp
    assign sample = (mem.read || mem.write) && !resp_q && !flush;

    always_ff @(posedge clk) begin
        if (sample && mem.write) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (mem.byte_en[b]) begin
                    ram_q[index][8*b +: 8] <= mem.wdata[8*b +: 8];
                end
            end
        end
        // loads return the whole aligned word
        if (sample && mem.read) begin
            rdata_q <= ram_q[index];
        end
    end

    // flush cancels the pending resp but keeps a write already done
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            resp_q <= 1'b0;
        end else begin
            resp_q <= sample;
        end
    end

    assign mem.resp  = resp_q;
    assign mem.rdata = rdata_q;

    // the queue holds a request until its resp
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (mem.read || mem.write) && !mem.resp |=> (mem.read || mem.write));

endmodule

`default_nettype wire

/* rtl/load_store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_queue (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     flush,
    input  logic                                     entry_valid,
    input  lsq_pkg::lsq_entry_t                      entry,
    input  logic [lsq_pkg::NUM_CDB-1:0]              cdb_valid,
    input  lsq_pkg::rob_tag_t [lsq_pkg::NUM_CDB-1:0] cdb_tag,
    input  lsq_pkg::word_t [lsq_pkg::NUM_CDB-1:0]    cdb_value,
    input  lsq_pkg::rob_tag_t                        head_tag,
    input  logic                                     head_is_store,
    output logic                                     lsq_full,
    output logic                                     load_valid,
    output lsq_pkg::rob_tag_t                        load_tag,
    output lsq_pkg::word_t                           load_value,
    output logic                                     store_done,
    dmem_if.lsq                                      mem
);
    import lsq_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READING,
        ST_WRITING,
        ST_DONE
    } state_t;

    lsq_entry_t queue_q [LSQ_DEPTH];
    lsq_ptr_t   head_q;
    lsq_ptr_t   tail_q;
    lsq_count_t count_q;
    state_t     state_q;

    // request registers toward the RAM
    word_t      addr_q;
    byte_en_t   byte_en_q;
    word_t      wdata_q;
    rob_tag_t   req_tag_q;
    logic       req_store_q;
    word_t      load_value_q;

    lsq_entry_t head;
    lsq_entry_t entry_in;
    logic       enq;
    logic       deq;
    logic       head_ready;
    word_t      ea;
    byte_en_t   lanes;
    word_t      lane_data;

    // capture any matching CDB broadcast into an entry
    function automatic lsq_entry_t snoop(input lsq_entry_t e);
        lsq_entry_t r;
        r = e;
        for (int j = 0; j < NUM_CDB; j++) begin
            if (cdb_valid[j] && e.qj != '0 && e.qj == cdb_tag[j]) begin
                r.qj = '0;
                r.vj = cdb_value[j];
            end
            if (cdb_valid[j] && e.qk != '0 && e.qk == cdb_tag[j]) begin
                r.qk = '0;
                r.vk = cdb_value[j];
            end
        end
        return r;
    endfunction

    assign head     = queue_q[head_q];
    assign enq      = entry_valid && !lsq_full;
    assign deq      = (state_q == ST_READING || state_q == ST_WRITING) && mem.resp;
    assign lsq_full = (count_q == lsq_count_t'(LSQ_DEPTH));

    // a broadcast in the same cycle as the enqueue is not lost
    always_comb begin
        entry_in       = snoop(entry);
        entry_in.valid = 1'b1;
    end

    // loads wait on the base only, stores also on data and the ROB grant
    always_comb begin
        head_ready = (count_q != '0) && head.valid && (head.qj == '0);
        if (head.is_store) begin
            head_ready = head_ready && (head.qk == '0) && head_is_store
                         && (head_tag == head.rob);
        end
    end

    assign ea = head.vj + head.imm;

    always_comb begin
        case (head.size)
            SIZE_BYTE: lanes = byte_en_t'(4'b0001 << ea[1:0]);
            SIZE_HALF: lanes = byte_en_t'(4'b0011 << {ea[1], 1'b0});
            SIZE_WORD: lanes = 4'b1111;
            default:   lanes = 4'b1111;
        endcase
    end

    // store data moved up into its byte lanes
    assign lane_data = head.vk << {ea[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                queue_q[i].valid <= 1'b0;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                queue_q[i] <= snoop(queue_q[i]);
            end
            if (deq) begin
                queue_q[head_q].valid <= 1'b0;
                head_q <= head_q + 1'b1;
            end
            if (enq) begin
                queue_q[tail_q] <= entry_in;
                tail_q <= tail_q + 1'b1;
            end
            count_q <= count_q + lsq_count_t'(enq) - lsq_count_t'(deq);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (head_ready) begin
                        state_q <= head.is_store ? ST_WRITING : ST_READING;
                    end
                end
                ST_READING, ST_WRITING: begin
                    if (mem.resp) begin
                        state_q <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // latched at issue and held for the whole request
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && head_ready) begin
            addr_q      <= ea;
            byte_en_q   <= head.is_store ? lanes : 4'b1111;
            wdata_q     <= lane_data;
            req_tag_q   <= head.rob;
            req_store_q <= head.is_store;
        end
        if (state_q == ST_READING && mem.resp) begin
            load_value_q <= mem.rdata;
        end
    end

    assign mem.read    = (state_q == ST_READING);
    assign mem.write   = (state_q == ST_WRITING);
    assign mem.addr    = addr_q;
    assign mem.byte_en = byte_en_q;
    assign mem.wdata   = wdata_q;

    // completion pulses come from the done state
    assign load_valid  = (state_q == ST_DONE) && !req_store_q;
    assign store_done  = (state_q == ST_DONE) && req_store_q;
    assign load_tag    = req_tag_q;
    assign load_value  = load_value_q;

    // the request kind follows the entry latched at issue
    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem.read && mem.write)
        && !(mem.read && req_store_q) && !(mem.write && !req_store_q));

    a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n)
        entry_valid |-> !lsq_full);

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (mem.read || mem.write) && !mem.resp |=>
            $stable(mem.addr) && $stable(mem.wdata) && $stable(mem.byte_en)
            && (mem.addr == ea));

endmodule

`default_nettype wire

/* rtl/dmem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dmem_if;
    import lsq_pkg::*;

    // request side, held until resp
    logic     read;
    logic     write;
    byte_en_t byte_en;
    word_t    addr;
    word_t    wdata;

    // response side
    logic     resp;
    word_t    rdata;

    modport lsq (
        output read, write, byte_en, addr, wdata,
        input  resp, rdata
    );

    modport ram (
        input  read, write, byte_en, addr, wdata,
        output resp, rdata
    );

endinterface

`default_nettype wire

/* rtl/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

    // core sizing
    localparam int ROB_ENTRIES = 8;
    localparam int LSQ_DEPTH   = 8;
    localparam int NUM_CDB     = 2;
    localparam int RAM_WORDS   = 256;

    typedef logic [31:0]                    word_t;
    // tag zero means no producer
    typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_tag_t;
    typedef logic [$clog2(LSQ_DEPTH)-1:0]   lsq_ptr_t;
    typedef logic [$clog2(LSQ_DEPTH):0]     lsq_count_t;
    typedef logic [1:0]                     mem_size_t;
    typedef logic [3:0]                     byte_en_t;
    typedef logic [$clog2(RAM_WORDS)-1:0]   ram_addr_t;

    // access sizes
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // one memory operation as handed over by the ROB
    typedef struct packed {
        logic      valid;
        logic      is_store;
        mem_size_t size;
        rob_tag_t  rob;
        rob_tag_t  qj;
        word_t     vj;
        rob_tag_t  qk;
        word_t     vk;
        word_t     imm;
    } lsq_entry_t;

endpackage

`default_nettype wire
